// ==== src/mipsIsaPkg.sv ====
package mipsIsaPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;

	// primary opcode field, instruction[31:26].
	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		J       = 6'h02,
		JAL     = 6'h03,
		BEQ     = 6'h04,
		BNE     = 6'h05,
		ADDIU   = 6'h09,
		ORI     = 6'h0d,
		LUI     = 6'h0f,
		LW      = 6'h23,
		SW      = 6'h2b
	} opcode_t;

	// function field of SPECIAL instructions.
	typedef enum logic [5:0] {
		JR   = 6'h08,
		JALR = 6'h09,
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		SLT  = 6'h2a
	} funct_t;

	// low bit of each field.
	parameter int opcodeLo = 26;
	parameter int rsLo     = 21;
	parameter int rtLo     = 16;
	parameter int rdLo     = 11;
	parameter int functLo  = 0;

	parameter int regAddrWidth = $bits(regAddr_t);
	parameter int fieldWidth   = $bits(opcode_t);

	parameter regAddr_t linkReg = 5'd31; // ra, target of jal.

endpackage

// ==== src/regCtrlPkg.sv ====
package regCtrlPkg;

	// which instruction field names the destination.
	typedef enum logic [1:0] {
		RD   = 2'd0,
		RT   = 2'd1,
		LINK = 2'd2
	} wrAddrSrc_e;

	// where the writeback data comes from.
	typedef enum logic [1:0] {
		ALU     = 2'd0,
		MEM     = 2'd1,
		PC_LINK = 2'd2
	} wrDataSrc_e;

	typedef struct packed {
		wrAddrSrc_e writeAddrSource;
		wrDataSrc_e writeDataSource;
		logic       writeEnable;
	} regControl_t;

	parameter regControl_t noWrite = '{
		writeAddrSource: RD,
		writeDataSource: ALU,
		writeEnable:     1'b0
	};

	// return address skips the delay slot.
	parameter mipsIsaPkg::word_t linkOffset = 32'd8;

endpackage

// ==== src/regPortsIf.sv ====
interface regPortsIf;
	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	regAddr_t   read1;
	regAddr_t   read2;
	regAddr_t   writeAddr;
	wrDataSrc_e writeDataSource;
	logic       writeEn;

	modport src (
		output read1, read2, writeAddr, writeDataSource, writeEn
	);

	modport dst (
		input read1, read2, writeAddr, writeDataSource, writeEn
	);

endinterface

// ==== src/registerControl.sv ====
module registerControl
	( input  mipsIsaPkg::opcode_t    opcode
	, input  mipsIsaPkg::funct_t     funct
	, output regCtrlPkg::regControl_t regControl
	);

	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	always_comb begin
		regControl = noWrite;
		case (opcode)
			SPECIAL: begin
				case (funct)
					ADDU, SUBU, AND, OR, SLT: begin
						regControl.writeAddrSource = RD;
						regControl.writeDataSource = ALU;
						regControl.writeEnable     = 1'b1;
					end
					JALR: begin
						regControl.writeAddrSource = RD;
						regControl.writeDataSource = PC_LINK;
						regControl.writeEnable     = 1'b1;
					end
					JR: regControl = noWrite; // jump only.
					default: regControl = noWrite;
				endcase
			end
			ADDIU, ORI, LUI: begin
				regControl.writeAddrSource = RT; // immediate forms.
				regControl.writeDataSource = ALU;
				regControl.writeEnable     = 1'b1;
			end
			LW: begin
				regControl.writeAddrSource = RT;
				regControl.writeDataSource = MEM;
				regControl.writeEnable     = 1'b1;
			end
			JAL: begin
				regControl.writeAddrSource = LINK;
				regControl.writeDataSource = PC_LINK;
				regControl.writeEnable     = 1'b1;
			end
			SW, BEQ, BNE, J: regControl = noWrite;
			default: regControl = noWrite; // unknown opcode.
		endcase
	end

endmodule

// ==== src/regAddrDecode.sv ====
module regAddrDecode
	( input  mipsIsaPkg::word_t      instruction
	, input  regCtrlPkg::wrAddrSrc_e writeAddrSource
	, output mipsIsaPkg::regAddr_t   rd1Addr
	, output mipsIsaPkg::regAddr_t   rd2Addr
	, output mipsIsaPkg::regAddr_t   wrAddr
	);

	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	regAddr_t rdField;

	assign rd1Addr = instruction[rsLo +: regAddrWidth]; // rs.
	assign rd2Addr = instruction[rtLo +: regAddrWidth]; // rt.
	assign rdField = instruction[rdLo +: regAddrWidth];

	always_comb begin
		case (writeAddrSource)
			RD:      wrAddr = rdField;
			RT:      wrAddr = rd2Addr;
			LINK:    wrAddr = linkReg;
			default: wrAddr = rdField;
		endcase
	end

endmodule

// ==== src/registerFile.sv ====
module registerFile #
	( parameter bit PASSTHROUGH = 0
	)
	( input  logic                 clk
	, input  logic                 reset
	, input  mipsIsaPkg::regAddr_t rd1Addr
	, input  mipsIsaPkg::regAddr_t rd2Addr
	, input  mipsIsaPkg::regAddr_t wrAddr
	, input  mipsIsaPkg::word_t    wrData
	, input  logic                 wrEnable
	, output mipsIsaPkg::word_t    rd1Data
	, output mipsIsaPkg::word_t    rd2Data
	);

	import mipsIsaPkg::*;

	word_t regs [32];

	logic commit;

	assign commit = wrEnable && (wrAddr != '0); // r0 is hard-wired.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (commit) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rd1Data = (rd1Addr == '0) ? '0
		: (PASSTHROUGH && commit && rd1Addr == wrAddr) ? wrData // same-cycle bypass.
		: regs[rd1Addr];
	assign rd2Data = (rd2Addr == '0) ? '0
		: (PASSTHROUGH && commit && rd2Addr == wrAddr) ? wrData
		: regs[rd2Addr];

	// r0 must still read back zero after any attempt to write it.
	assert property (@(posedge clk) disable iff (reset)
		(wrEnable && wrAddr == '0) |=> regs[0] == '0)
		else $error("write to r0 was committed");

	// delay line is flushed by the same reset.
	assert property (@(posedge clk)
		$fell(reset) |-> !wrEnable)
		else $error("write request right after reset");

endmodule

// ==== src/regDatapath.sv ====
module regDatapath #
	( parameter bit PASSTHROUGH = 0
	)
	( input  logic                    clk
	, input  logic                    reset
	, input  regCtrlPkg::regControl_t regControl
	, input  mipsIsaPkg::word_t       instruction
	, input  mipsIsaPkg::word_t       pcAddr
	, input  mipsIsaPkg::word_t       memOut
	, input  mipsIsaPkg::word_t       aluResult
	, regPortsIf.dst                  portsIn
	, regPortsIf.src                  portsOut
	, output mipsIsaPkg::word_t       port1
	, output mipsIsaPkg::word_t       port2
	, output logic                    portEq
	);

	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	regAddr_t rd1Addr;
	regAddr_t rd2Addr;
	regAddr_t wrAddr;
	word_t    wrData;

	regAddrDecode u_addrDecode
		( .instruction     (instruction)
		, .writeAddrSource (regControl.writeAddrSource)
		, .rd1Addr         (rd1Addr)
		, .rd2Addr         (rd2Addr)
		, .wrAddr          (wrAddr)
		);

	// data source comes back with the request, data is sampled now.
	always_comb begin
		case (portsIn.writeDataSource)
			ALU:     wrData = aluResult;
			MEM:     wrData = memOut;
			PC_LINK: wrData = pcAddr + linkOffset;
			default: wrData = aluResult;
		endcase
	end

	registerFile #
		( .PASSTHROUGH (PASSTHROUGH)
		) u_regFile
		( .clk      (clk)
		, .reset    (reset)
		, .rd1Addr  (rd1Addr)
		, .rd2Addr  (rd2Addr)
		, .wrAddr   (portsIn.writeAddr)
		, .wrData   (wrData)
		, .wrEnable (portsIn.writeEn)
		, .rd1Data  (port1)
		, .rd2Data  (port2)
		);

	assign portEq = port1 == port2; // branch compare.

	// outgoing request.
	assign portsOut.read1           = rd1Addr;
	assign portsOut.read2           = rd2Addr;
	assign portsOut.writeAddr       = wrAddr;
	assign portsOut.writeDataSource = regControl.writeDataSource;
	assign portsOut.writeEn         = regControl.writeEnable;

endmodule

// ==== src/wbDelayLine.sv ====
module wbDelayLine #
	( parameter int WB_LATENCY = 3
	)
	( input logic    clk
	, input logic    reset
	, regPortsIf.dst requestIn
	, regPortsIf.src requestOut
	);

	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	typedef struct packed {
		regAddr_t   read1;
		regAddr_t   read2;
		regAddr_t   writeAddr;
		wrDataSrc_e writeDataSource;
		logic       writeEn;
	} request_t;

	request_t stages [WB_LATENCY];

	always_ff @(posedge clk) begin
		stages[0] <= '{requestIn.read1, requestIn.read2, requestIn.writeAddr,
			requestIn.writeDataSource, requestIn.writeEn};
		for (int i = 1; i < WB_LATENCY; i++)
			stages[i] <= stages[i - 1];
		if (reset) begin
			for (int i = 0; i < WB_LATENCY; i++)
				stages[i].writeEn <= 1'b0; // payload may stay stale.
		end
	end

	assign requestOut.read1           = stages[WB_LATENCY - 1].read1;
	assign requestOut.read2           = stages[WB_LATENCY - 1].read2;
	assign requestOut.writeAddr       = stages[WB_LATENCY - 1].writeAddr;
	assign requestOut.writeDataSource = stages[WB_LATENCY - 1].writeDataSource;
	assign requestOut.writeEn         = stages[WB_LATENCY - 1].writeEn;

	assert property (@(posedge clk) WB_LATENCY inside {[1:8]})
		else $error("WB_LATENCY out of range");

endmodule

// ==== src/regStage.sv ====
module regStage #
	( parameter bit PASSTHROUGH = 0
	, parameter int WB_LATENCY  = 3
	)
	( input  logic              clk
	, input  logic              reset
	, input  mipsIsaPkg::word_t instruction
	, input  mipsIsaPkg::word_t pcAddr
	, input  mipsIsaPkg::word_t aluResult
	, input  mipsIsaPkg::word_t memOut
	, output mipsIsaPkg::word_t port1
	, output mipsIsaPkg::word_t port2
	, output logic              portEq
	);

	import mipsIsaPkg::*;
	import regCtrlPkg::*;

	regControl_t regControl;

	regPortsIf portsOut ();
	regPortsIf portsIn ();

	registerControl u_control
		( .opcode     (opcode_t'(instruction[opcodeLo +: fieldWidth]))
		, .funct      (funct_t'(instruction[functLo +: fieldWidth]))
		, .regControl (regControl)
		);

	regDatapath #
		( .PASSTHROUGH (PASSTHROUGH)
		) u_datapath
		( .clk         (clk)
		, .reset       (reset)
		, .regControl  (regControl)
		, .instruction (instruction)
		, .pcAddr      (pcAddr)
		, .memOut      (memOut)
		, .aluResult   (aluResult)
		, .portsIn     (portsIn.dst)
		, .portsOut    (portsOut.src)
		, .port1       (port1)
		, .port2       (port2)
		, .portEq      (portEq)
		);

	// stands in for execute and memory.
	wbDelayLine #
		( .WB_LATENCY (WB_LATENCY)
		) u_wbDelay
		( .clk        (clk)
		, .reset      (reset)
		, .requestIn  (portsOut.dst)
		, .requestOut (portsIn.src)
		);

endmodule

// ==== testbench/tb_regStage.sv ====
module tb_regStage;

	import mipsIsaPkg::*;

	localparam int    clkPeriod  = 4;
	localparam int    driveDelay = 1;
	localparam string tracePath  = "testbench/regStage_trace.txt";

	logic  clk;
	logic  reset;
	word_t instruction;
	word_t pcAddr;
	word_t aluResult;
	word_t memOut;
	word_t port1;
	word_t port2;
	logic  portEq;

	// one entry per trace line.
	word_t instrQ [$];
	word_t pcQ [$];
	word_t aluQ [$];
	word_t memQ [$];
	word_t exp1Q [$];
	word_t exp2Q [$];
	logic  expEqQ [$];

	int     errorCount  = 0;
	int     checkCount  = 0;
	int     lineCount   = 0;
	bit     traceLoaded = 0;
	longint watchLimit  = 0;

	regStage #
		( .PASSTHROUGH (1)
		, .WB_LATENCY  (3)
		) u_dut
		( .clk         (clk)
		, .reset       (reset)
		, .instruction (instruction)
		, .pcAddr      (pcAddr)
		, .aluResult   (aluResult)
		, .memOut      (memOut)
		, .port1       (port1)
		, .port2       (port2)
		, .portEq      (portEq)
		);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic loadTrace();
		int          fd;
		int          fields;
		int          lineNo;
		string       lineText;
		logic [31:0] v [7];
		fd = $fopen(tracePath, "r");
		if (fd == 0) begin
			$display("could not open trace file %s", tracePath);
			errorCount++;
			return;
		end
		lineNo = 0;
		while ($fgets(lineText, fd) != 0) begin
			lineNo++;
			if (lineText.len() == 0 || lineText[0] == "#" || lineText[0] == "\n")
				continue; // comments and blank lines.
			fields = $sscanf(lineText, "%h %h %h %h %h %h %h",
				v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
			if (fields != 7) begin
				$display("trace line %0d holds %0d fields where 7 are needed", lineNo, fields);
				errorCount++;
				continue;
			end
			instrQ.push_back(v[0]);
			pcQ.push_back(v[1]);
			aluQ.push_back(v[2]);
			memQ.push_back(v[3]);
			exp1Q.push_back(v[4]);
			exp2Q.push_back(v[5]);
			expEqQ.push_back(v[6][0]);
		end
		$fclose(fd);
		lineCount = instrQ.size();
		if (lineCount == 0) begin
			$display("trace file %s holds no stimulus lines", tracePath);
			errorCount++;
		end
	endtask

	task automatic applyLine(input int i);
		instruction = instrQ[i];
		pcAddr      = pcQ[i];
		aluResult   = aluQ[i];
		memOut      = memQ[i];
	endtask

	task automatic checkLine(input int i);
		checkCount++;
		assert (port1 === exp1Q[i]) else begin
			$display("Error: port1 at line %0d expected %08h, got %08h", i, exp1Q[i], port1);
			errorCount++;
		end
		assert (port2 === exp2Q[i]) else begin
			$display("Error: port2 at line %0d expected %08h, got %08h", i, exp2Q[i], port2);
			errorCount++;
		end
		assert (portEq === expEqQ[i]) else begin
			$display("Error: portEq at line %0d expected %h, got %h", i, expEqQ[i], portEq);
			errorCount++;
		end
	endtask

	initial begin
		reset       = 1'b1;
		instruction = '0;
		pcAddr      = '0;
		aluResult   = '0;
		memOut      = '0;
		loadTrace();
		watchLimit  = (lineCount + 10) * clkPeriod * 2;
		traceLoaded = 1'b1;
		repeat (3) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;
		for (int i = 0; i < lineCount; i++) begin
			applyLine(i);
			#(clkPeriod / 2); // sample just before the next edge.
			checkLine(i);
			@(posedge clk);
			#(driveDelay);
		end
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (traceLoaded);
		#(watchLimit);
		$display("run stopped by the watchdog after %0d time units", watchLimit);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== testbench/regStage_trace.txt ====
# columns in hex: instruction pcAddr aluResult memOut port1 port2 portEq
# writeback data (aluResult, memOut, pcAddr+8) sits on the line three cycles after issue
10a60004 00400000 00000000 00000000 00000000 00000000 1
17f10008 00400004 00000000 00000000 00000000 00000000 1
24011234 00400008 00000000 00000000 00000000 00000000 1
3402beef 0040000c 00000000 00000000 00000000 00000000 1
00221821 00400010 00000000 00000000 00000000 00000000 1
10200010 00400014 00001234 5a5a5a5a 00001234 00000000 0
8c440000 00400018 0000beef 11111111 0000beef 00000000 0
0c030000 0040001c 0000d123 5a5a5a5a 00000000 0000d123 0
00602809 00400020 0f0f0f0f 5a5a5a5a 0000d123 00000000 0
ac240004 00400024 22222222 cafef00d 00001234 cafef00d 0
17e30002 00400028 44444444 5a5a5a5a 00400030 0000d123 0
08050000 0040002c 55555555 66666666 00000000 00400034 0
03e00008 00400030 33333333 77777777 00400030 00000000 0
24000055 00400034 00000000 00000000 00000000 00000000 1
24060077 00400038 99999999 00000000 00000000 00000000 1
24070088 0040003c 88888888 00000000 00000000 00000000 1
34081234 00400040 deadbeef 00000000 00000000 00000000 1
10c70003 00400044 00000077 00000000 00000077 00000000 0
10e60001 00400048 00000088 00000000 00000088 00000077 0
11010002 0040004c 00001234 00000000 00001234 00001234 1
10820005 00400050 00000000 00000000 cafef00d 0000beef 0
17e50001 00400054 00000000 00000000 00400030 00400034 0
00634821 00400058 00000000 00000000 0000d123 0000d123 1
3c0aabcd 0040005c 00000000 00000000 00000000 00000000 1
10090000 00400060 00000000 00000000 00000000 00000000 1
112a0000 00400064 0001a246 00000000 0001a246 00000000 0
11490000 00400068 abcd0000 00000000 abcd0000 0001a246 0
14c80000 0040006c 00000000 00000000 00000077 00001234 0

// ==== regStage.f ====
src/mipsIsaPkg.sv
src/regCtrlPkg.sv
src/regPortsIf.sv
src/registerControl.sv
src/regAddrDecode.sv
src/registerFile.sv
src/regDatapath.sv
src/wbDelayLine.sv
src/regStage.sv
testbench/tb_regStage.sv

// ==== Bender.yml ====
package:
  name: regStage

sources:
  - src/mipsIsaPkg.sv
  - src/regCtrlPkg.sv
  - src/regPortsIf.sv
  - src/registerControl.sv
  - src/regAddrDecode.sv
  - src/registerFile.sv
  - src/regDatapath.sv
  - src/wbDelayLine.sv
  - src/regStage.sv
  - target: test
    files:
      - testbench/tb_regStage.sv
